// ==== src/axicb_pkg.sv ====
/* Shared widths and payload types of the crossbar slice.
   ID bits 5:4 carry the master index, so MST_NB may not exceed four */

package axicb_pkg;

    //////////////////////////////
    // Sizes
    //////////////////////////////

    localparam int MST_NB     = 4;
    localparam int MST_IDX_W  = $clog2(MST_NB);
    localparam int ID_W       = 8;
    // Lowest bit of the master index inside an ID
    localparam int MST_ID_LSB = 4;
    localparam int ADDR_W     = 8;
    localparam int DATA_W     = 8;
    // Burst length holds beats minus one
    localparam int LEN_W      = 4;
    localparam int RESP_W     = 2;
    localparam int MEM_DEPTH  = 2**ADDR_W;

    //////////////////////////////
    // Types
    //////////////////////////////

    typedef logic [ID_W-1:0]      id_t;
    typedef logic [ADDR_W-1:0]    addr_t;
    typedef logic [DATA_W-1:0]    data_t;
    typedef logic [LEN_W-1:0]     len_t;
    typedef logic [RESP_W-1:0]    resp_t;
    typedef logic [MST_NB-1:0]    mst_vec_t;
    typedef logic [MST_IDX_W-1:0] mst_idx_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // Address payload for AW and AR, ID in the low bits
    typedef struct packed {
        len_t  len;
        addr_t addr;
        id_t   id;
    } addr_ch_t;

    typedef struct packed {
        resp_t resp;
        id_t   id;
    } bch_t;

    typedef struct packed {
        resp_t resp;
        data_t data;
        id_t   id;
    } rch_t;

    typedef enum logic [1:0] {IDLE, WRITE, WRESP, READ} slv_state_t;

endpackage

// ==== src/axicb_slv_if.sv ====
/* Single link from the switch to the slave, all five channels.
   No clock inside, both ends sample on their own i_aclk */

interface axicb_slv_if import axicb_pkg::*; ();

    // Write address
    logic     awvalid;
    logic     awready;
    addr_ch_t awch;

    // Write data
    logic     wvalid;
    logic     wready;
    logic     wlast;
    data_t    wch;

    // Write response
    logic     bvalid;
    logic     bready;
    bch_t     bch;

    // Read address
    logic     arvalid;
    logic     arready;
    addr_ch_t arch;

    // Read data
    logic     rvalid;
    logic     rready;
    logic     rlast;
    rch_t     rch;

    modport mst (
        output awvalid, awch, wvalid, wlast, wch, bready, arvalid, arch, rready,
        input  awready, wready, bvalid, bch, arready, rvalid, rlast, rch
    );

    modport slv (
        input  awvalid, awch, wvalid, wlast, wch, bready, arvalid, arch, rready,
        output awready, wready, bvalid, bch, arready, rvalid, rlast, rch
    );

endinterface

// ==== src/axicb_round_robin.sv ====
/* Round-robin over MST_NB requesters, master 0 first after reset.
   Requesters must hold their request until accepted */

module axicb_round_robin import axicb_pkg::*; (
    input  logic     i_aclk,
    input  logic     i_rst_n,
    input  logic     i_en,
    input  mst_vec_t i_req,
    output mst_vec_t o_grant
);

    // Index of the previous winner
    mst_idx_t last_q;
    mst_idx_t win_idx;
    logic     win_found;
    // Grant held stable while the winner waits
    logic     lock_q;
    mst_idx_t lock_idx_q;
    mst_idx_t cur_idx;

    //////////////////////////////
    // Search above the last winner
    //////////////////////////////

    always_comb begin
        mst_idx_t cand;
        win_idx   = last_q;
        win_found = 1'b0;
        for (int i = 1; i <= MST_NB; i++) begin
            cand = mst_idx_t'((int'(last_q) + i) % MST_NB);
            if (!win_found && i_req[cand]) begin
                win_idx   = cand;
                win_found = 1'b1;
            end
        end
    end

    assign cur_idx = lock_q ? lock_idx_q : win_idx;
    assign o_grant = (lock_q || win_found) ? mst_vec_t'(1) << cur_idx : '0;

    //////////////////////////////
    // Pointer and lock
    //////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            last_q <= mst_idx_t'(MST_NB - 1);
            lock_q <= 1'b0;
        end else if (i_en) begin
            last_q <= cur_idx;
            lock_q <= 1'b0;
        end else if (win_found) begin
            lock_q <= 1'b1;
        end
    end

    always_ff @(posedge i_aclk) begin
        if (win_found && !lock_q) begin
            lock_idx_q <= win_idx;
        end
    end

endmodule

// ==== src/axicb_scfifo.sv ====
/* Holds one-hot write grants in address order, 2**DEPTH_LOG2 entries.
   Push while full and pull while empty are ignored */

module axicb_scfifo import axicb_pkg::*; #(
    parameter int DEPTH_LOG2 = 2
) (
    input  logic     i_aclk,
    input  logic     i_rst_n,
    input  logic     i_push,
    input  mst_vec_t i_data,
    output logic     o_full,
    input  logic     i_pull,
    output mst_vec_t o_data,
    output logic     o_empty
);

    localparam int DEPTH = 2**DEPTH_LOG2;

    mst_vec_t              mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr_q;
    logic [DEPTH_LOG2-1:0] rd_ptr_q;
    logic [DEPTH_LOG2:0]   count_q;
    logic                  do_push;
    logic                  do_pull;

    assign o_full  = (count_q == DEPTH[DEPTH_LOG2:0]);
    assign o_empty = (count_q == '0);
    assign do_push = i_push && !o_full;
    assign do_pull = i_pull && !o_empty;
    assign o_data  = mem[rd_ptr_q];

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pull) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pull keep the count
            if (do_push && !do_pull) begin
                count_q <= count_q + 1'b1;
            end else if (do_pull && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge i_aclk) begin
        if (do_push) begin
            mem[wr_ptr_q] <= i_data;
        end
    end

endmodule

// ==== src/axicb_mst_switch.sv ====
/* Four masters onto one slave, purely combinational data paths.
   Responses are routed by ID bits 5:4, so each master must put its index there */

module axicb_mst_switch import axicb_pkg::*; (
    input  logic                  i_aclk,
    input  logic                  i_rst_n,
    input  mst_vec_t              i_awvalid,
    output mst_vec_t              o_awready,
    input  addr_ch_t [MST_NB-1:0] i_awch,
    input  mst_vec_t              i_wvalid,
    output mst_vec_t              o_wready,
    input  mst_vec_t              i_wlast,
    input  data_t    [MST_NB-1:0] i_wch,
    output mst_vec_t              o_bvalid,
    input  mst_vec_t              i_bready,
    output bch_t                  o_bch,
    input  mst_vec_t              i_arvalid,
    output mst_vec_t              o_arready,
    input  addr_ch_t [MST_NB-1:0] i_arch,
    output mst_vec_t              o_rvalid,
    input  mst_vec_t              i_rready,
    output mst_vec_t              o_rlast,
    output rch_t                  o_rch,
    axicb_slv_if.mst              slv
);

    mst_vec_t aw_grant;
    logic     aw_en;
    mst_vec_t ar_grant;
    logic     ar_en;
    mst_vec_t w_head;
    mst_vec_t w_sel;
    logic     w_full;
    logic     w_empty;
    mst_idx_t b_idx;
    mst_idx_t r_idx;

    // Address payload of the granted master
    function automatic addr_ch_t pick_addr(input mst_vec_t grant,
                                           input addr_ch_t [MST_NB-1:0] chans);
        addr_ch_t sel;
        sel = '0;
        for (int i = 0; i < MST_NB; i++) begin
            if (grant[i]) begin
                sel = chans[i];
            end
        end
        return sel;
    endfunction

    //////////////////////////////
    // Write address
    //////////////////////////////

    axicb_round_robin u_aw_arb (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_en    (aw_en),
        .i_req   (i_awvalid),
        .o_grant (aw_grant)
    );

    // No new burst while the grant FIFO cannot record it
    assign slv.awvalid = |(aw_grant & i_awvalid) && !w_full;
    assign slv.awch    = pick_addr(aw_grant, i_awch);
    assign o_awready   = aw_grant & {MST_NB{slv.awready && !w_full}};
    assign aw_en       = slv.awvalid && slv.awready;

    //////////////////////////////
    // Write data
    //////////////////////////////

    axicb_scfifo #(
        .DEPTH_LOG2 (2)
    ) u_w_fifo (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_push  (aw_en),
        .i_data  (aw_grant),
        .o_full  (w_full),
        .i_pull  (slv.wvalid && slv.wready && slv.wlast),
        .o_data  (w_head),
        .o_empty (w_empty)
    );

    assign w_sel      = w_empty ? '0 : w_head;
    assign slv.wvalid = |(w_sel & i_wvalid);
    assign slv.wlast  = |(w_sel & i_wlast);
    assign o_wready   = w_sel & {MST_NB{slv.wready}};

    always_comb begin
        slv.wch = '0;
        for (int i = 0; i < MST_NB; i++) begin
            if (w_sel[i]) begin
                slv.wch = i_wch[i];
            end
        end
    end

    //////////////////////////////
    // Read address
    //////////////////////////////

    axicb_round_robin u_ar_arb (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .i_en    (ar_en),
        .i_req   (i_arvalid),
        .o_grant (ar_grant)
    );

    assign slv.arvalid = |(ar_grant & i_arvalid);
    assign slv.arch    = pick_addr(ar_grant, i_arch);
    assign o_arready   = ar_grant & {MST_NB{slv.arready}};
    assign ar_en       = slv.arvalid && slv.arready;

    //////////////////////////////
    // Responses, routed by ID
    //////////////////////////////

    assign b_idx      = slv.bch.id[MST_ID_LSB +: MST_IDX_W];
    assign o_bch      = slv.bch;
    assign o_bvalid   = slv.bvalid ? mst_vec_t'(1) << b_idx : '0;
    assign slv.bready = i_bready[b_idx];

    assign r_idx      = slv.rch.id[MST_ID_LSB +: MST_IDX_W];
    assign o_rch      = slv.rch;
    assign o_rvalid   = slv.rvalid ? mst_vec_t'(1) << r_idx : '0;
    assign o_rlast    = slv.rlast ? mst_vec_t'(1) << r_idx : '0;
    assign slv.rready = i_rready[r_idx];

endmodule

// ==== src/axicb_ram_slave.sv ====
/* 256-byte burst memory, one burst at a time, AW wins over AR in IDLE.
   Always answers OKAY and wraps the address at the top of memory */

module axicb_ram_slave import axicb_pkg::*; (
    input  logic     i_aclk,
    input  logic     i_rst_n,
    axicb_slv_if.slv mst
);

    data_t      mem [MEM_DEPTH];
    slv_state_t state_q;
    addr_t      addr_q;
    id_t        id_q;
    // Read beats left after the current one
    len_t       beat_q;
    logic       aw_hs;
    logic       w_hs;
    logic       ar_hs;
    logic       r_hs;

    assign mst.awready = (state_q == IDLE);
    assign mst.arready = (state_q == IDLE) && !mst.awvalid;
    assign mst.wready  = (state_q == WRITE);
    assign mst.bvalid  = (state_q == WRESP);
    assign mst.bch     = '{resp: RESP_OKAY, id: id_q};
    assign mst.rvalid  = (state_q == READ);
    assign mst.rlast   = (state_q == READ) && (beat_q == '0);
    assign mst.rch     = '{resp: RESP_OKAY, data: mem[addr_q], id: id_q};

    assign aw_hs = mst.awvalid && mst.awready;
    assign w_hs  = mst.wvalid && mst.wready;
    assign ar_hs = mst.arvalid && mst.arready;
    assign r_hs  = mst.rvalid && mst.rready;

    //////////////////////////////
    // FSM
    //////////////////////////////

    always_ff @(posedge i_aclk) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            case (state_q)
                IDLE: begin
                    if (aw_hs) begin
                        state_q <= WRITE;
                    end else if (ar_hs) begin
                        state_q <= READ;
                    end
                end
                WRITE: if (w_hs && mst.wlast) state_q <= WRESP;
                WRESP: if (mst.bready) state_q <= IDLE;
                READ:  if (r_hs && beat_q == '0) state_q <= IDLE;
                default: state_q <= IDLE;
            endcase
        end
    end

    // Burst address and ID, loaded on acceptance
    always_ff @(posedge i_aclk) begin
        if (aw_hs) begin
            addr_q <= mst.awch.addr;
            id_q   <= mst.awch.id;
        end else if (ar_hs) begin
            addr_q <= mst.arch.addr;
            id_q   <= mst.arch.id;
            beat_q <= mst.arch.len;
        end else if (w_hs || r_hs) begin
            addr_q <= addr_q + addr_t'(1);
        end
        if (r_hs) begin
            beat_q <= beat_q - len_t'(1);
        end
    end

    always_ff @(posedge i_aclk) begin
        if (w_hs) begin
            mem[addr_q] <= mst.wch;
        end
    end

endmodule

// ==== src/axicb_top.sv ====
/* Crossbar slice, four masters sharing one burst memory.
   Master lanes are packed, lane i belongs to master i */

module axicb_top import axicb_pkg::*; (
    input  logic                  i_aclk,
    input  logic                  i_rst_n,
    // Write address
    input  mst_vec_t              i_awvalid,
    output mst_vec_t              o_awready,
    input  addr_ch_t [MST_NB-1:0] i_awch,
    // Write data
    input  mst_vec_t              i_wvalid,
    output mst_vec_t              o_wready,
    input  mst_vec_t              i_wlast,
    input  data_t    [MST_NB-1:0] i_wch,
    // Write response, payload shared by all masters
    output mst_vec_t              o_bvalid,
    input  mst_vec_t              i_bready,
    output bch_t                  o_bch,
    // Read address
    input  mst_vec_t              i_arvalid,
    output mst_vec_t              o_arready,
    input  addr_ch_t [MST_NB-1:0] i_arch,
    // Read data, payload shared by all masters
    output mst_vec_t              o_rvalid,
    input  mst_vec_t              i_rready,
    output mst_vec_t              o_rlast,
    output rch_t                  o_rch
);

    axicb_slv_if slv_if ();

    axicb_mst_switch u_switch (
        .i_aclk    (i_aclk),
        .i_rst_n   (i_rst_n),
        .i_awvalid (i_awvalid),
        .o_awready (o_awready),
        .i_awch    (i_awch),
        .i_wvalid  (i_wvalid),
        .o_wready  (o_wready),
        .i_wlast   (i_wlast),
        .i_wch     (i_wch),
        .o_bvalid  (o_bvalid),
        .i_bready  (i_bready),
        .o_bch     (o_bch),
        .i_arvalid (i_arvalid),
        .o_arready (o_arready),
        .i_arch    (i_arch),
        .o_rvalid  (o_rvalid),
        .i_rready  (i_rready),
        .o_rlast   (o_rlast),
        .o_rch     (o_rch),
        .slv       (slv_if.mst)
    );

    axicb_ram_slave u_slave (
        .i_aclk  (i_aclk),
        .i_rst_n (i_rst_n),
        .mst     (slv_if.slv)
    );

endmodule

// ==== bench/axicb_checker.sv ====
/* Assertions on the master-side ports of axicb_top, bound from the testbench.
   Silent while reset is asserted; n_fail counts the failed assertions */

module axicb_checker import axicb_pkg::*; (
    input logic     i_aclk,
    input logic     i_rst_n,
    input mst_vec_t o_awready,
    input mst_vec_t o_arready,
    input mst_vec_t o_bvalid,
    input mst_vec_t i_bready,
    input bch_t     o_bch,
    input mst_vec_t o_rvalid,
    input mst_vec_t i_rready,
    input rch_t     o_rch
);

    timeunit 1ns;
    timeprecision 100ps;

    int n_fail = 0;

    // Lane of the master named by an ID
    function automatic mst_vec_t id_lane(input id_t id);
        return mst_vec_t'(1) << id[MST_ID_LSB +: MST_IDX_W];
    endfunction

    //////////////////////////////
    // Routing and arbitration
    //////////////////////////////

    b_route: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        (o_bvalid != '0) |-> (o_bvalid == id_lane(o_bch.id)))
        else begin
            $error("Write response raised on a lane other than its ID");
            n_fail++;
        end

    r_route: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
        (o_rvalid != '0) |-> (o_rvalid == id_lane(o_rch.id)))
        else begin
            $error("Read data raised on a lane other than its ID");
            n_fail++;
        end

    aw_one: assert property (@(posedge i_aclk) disable iff (!i_rst_n) $onehot0(o_awready))
        else begin
            $error("More than one write address ready at once");
            n_fail++;
        end

    ar_one: assert property (@(posedge i_aclk) disable iff (!i_rst_n) $onehot0(o_arready))
        else begin
            $error("More than one read address ready at once");
            n_fail++;
        end

    //////////////////////////////
    // Valid held until ready
    //////////////////////////////

    for (genvar i = 0; i < MST_NB; i++) begin : g_hold
        b_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
            o_bvalid[i] && !i_bready[i] |=> o_bvalid[i])
            else begin
                $error("Write response on master %0d dropped before ready", i);
                n_fail++;
            end

        r_hold: assert property (@(posedge i_aclk) disable iff (!i_rst_n)
            o_rvalid[i] && !i_rready[i] |=> o_rvalid[i])
            else begin
                $error("Read data on master %0d dropped before ready", i);
                n_fail++;
            end
    end

endmodule

// ==== bench/axicb_tb.sv ====
/* Directed testbench that drives inputs on the falling edge and samples outputs 1 ns later.
   Outputs hold from there until the next rising edge */

module axicb_tb import axicb_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 4;
    // Rough lengths of the five tests in cycles
    localparam int TEST_CYCLES = 30 + 60 + 80 + 50 + 60;
    localparam int WATCHDOG_NS = TEST_CYCLES * 20 * CLK_PERIOD;

    logic                  aclk;
    logic                  rst_n;
    mst_vec_t              awvalid;
    mst_vec_t              awready;
    addr_ch_t [MST_NB-1:0] awch;
    mst_vec_t              wvalid;
    mst_vec_t              wready;
    mst_vec_t              wlast;
    data_t    [MST_NB-1:0] wch;
    mst_vec_t              bvalid;
    mst_vec_t              bready;
    bch_t                  bch;
    mst_vec_t              arvalid;
    mst_vec_t              arready;
    addr_ch_t [MST_NB-1:0] arch;
    mst_vec_t              rvalid;
    mst_vec_t              rready;
    mst_vec_t              rlast;
    rch_t                  rch;

    // Expected memory contents
    data_t       model [MEM_DEPTH];
    logic [31:0] rand_state = 32'h5567_803d;
    mst_vec_t    ar_order [$];
    mst_vec_t    w_done;
    int          b_seen [MST_NB];
    int          n_value_err = 0;
    int          n_proto_err = 0;

    axicb_top UUT (
        .i_aclk    (aclk),
        .i_rst_n   (rst_n),
        .i_awvalid (awvalid),
        .o_awready (awready),
        .i_awch    (awch),
        .i_wvalid  (wvalid),
        .o_wready  (wready),
        .i_wlast   (wlast),
        .i_wch     (wch),
        .o_bvalid  (bvalid),
        .i_bready  (bready),
        .o_bch     (bch),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .i_arch    (arch),
        .o_rvalid  (rvalid),
        .i_rready  (rready),
        .o_rlast   (rlast),
        .o_rch     (rch)
    );

    bind axicb_top axicb_checker u_checker (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
        $display("Test FAILED");
        $finish;
    end

    // Count write response handshakes per master
    always begin
        @(negedge aclk);
        #1;
        for (int m = 0; m < MST_NB; m++) begin
            if (bvalid[m] && bready[m]) begin
                b_seen[m]++;
            end
        end
    end

    //////////////////////////////
    // Helpers
    //////////////////////////////

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic id_t make_id(input int m, input int nib);
        return id_t'((m << MST_ID_LSB) | nib);
    endfunction

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            $display("Fail %s: expected ID %h, actual %h", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_resp(input string name, input resp_t exp, input resp_t act);
        if (act !== exp) begin
            $display("Fail %s: expected resp %b, actual %b", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic check_grant(input string name, input mst_vec_t exp, input mst_vec_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            n_value_err++;
        end
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        repeat (5) @(negedge aclk);
        rst_n = 1'b1;
    endtask

    task automatic fill_model(input addr_t addr, input int beats);
        logic [31:0] r;
        for (int k = 0; k < beats; k++) begin
            r = next_rand();
            model[addr_t'(int'(addr) + k)] = r[23:16];
        end
    endtask

    //////////////////////////////
    // Channel drivers
    //////////////////////////////

    task automatic send_aw(input int m, input id_t id, input addr_t addr, input len_t len);
        @(negedge aclk);
        awch[m]    = '{len: len, addr: addr, id: id};
        awvalid[m] = 1'b1;
        #1;
        while (!awready[m]) begin
            @(negedge aclk);
            #1;
        end
        @(negedge aclk);
        awvalid[m] = 1'b0;
    endtask

    task automatic send_ar(input int m, input id_t id, input addr_t addr, input len_t len);
        @(negedge aclk);
        arch[m]    = '{len: len, addr: addr, id: id};
        arvalid[m] = 1'b1;
        #1;
        while (!arready[m]) begin
            @(negedge aclk);
            #1;
        end
        ar_order.push_back(arready);
        @(negedge aclk);
        arvalid[m] = 1'b0;
    endtask

    // Beats come from the model
    task automatic send_w(input int m, input addr_t addr, input int beats);
        for (int k = 0; k < beats; k++) begin
            @(negedge aclk);
            wch[m]    = model[addr_t'(int'(addr) + k)];
            wlast[m]  = (k == beats - 1);
            wvalid[m] = 1'b1;
            #1;
            while (!wready[m]) begin
                @(negedge aclk);
                #1;
            end
        end
        w_done[m] = 1'b1;
        @(negedge aclk);
        wvalid[m] = 1'b0;
        wlast[m]  = 1'b0;
    endtask

    task automatic recv_b(input int m, input id_t id, input string name);
        @(negedge aclk);
        bready[m] = 1'b1;
        #1;
        while (!bvalid[m]) begin
            @(negedge aclk);
            #1;
        end
        check_id(name, id, bch.id);
        check_resp(name, RESP_OKAY, bch.resp);
        @(negedge aclk);
        bready[m] = 1'b0;
    endtask

    task automatic recv_r(input int m, input id_t id, input addr_t addr, input int beats,
                          input bit gaps, input string name);
        int          k;
        bit          held;
        data_t       held_data;
        logic [31:0] r;
        mst_vec_t    exp_last;
        k    = 0;
        held = 1'b0;
        while (k < beats) begin
            @(negedge aclk);
            r         = next_rand();
            rready[m] = !gaps || (r[29:28] != 2'b00);
            #1;
            if (rvalid[m]) begin
                if (held) begin
                    check_data({name, "_hold"}, held_data, rch.data);
                end
                held = !rready[m];
                held_data = rch.data;
                if (rready[m]) begin
                    check_data(name, model[addr_t'(int'(addr) + k)], rch.data);
                    check_id(name, id, rch.id);
                    check_resp(name, RESP_OKAY, rch.resp);
                    exp_last = (k == beats - 1) ? mst_vec_t'(1) << m : '0;
                    check_grant({name, "_last"}, exp_last, rlast);
                    k++;
                end
            end
        end
        @(negedge aclk);
        rready[m] = 1'b0;
    endtask

    task automatic do_write(input int m, input id_t id, input addr_t addr, input int beats,
                            input string name);
        fork
            send_aw(m, id, addr, len_t'(beats - 1));
            send_w(m, addr, beats);
            recv_b(m, id, name);
        join
    endtask

    task automatic do_read(input int m, input id_t id, input addr_t addr, input int beats,
                           input bit gaps, input string name);
        fork
            send_ar(m, id, addr, len_t'(beats - 1));
            recv_r(m, id, addr, beats, gaps, name);
        join
    endtask

    task automatic check_ar_order(input string name, input int first);
        for (int i = 0; i < MST_NB; i++) begin
            check_grant(name, mst_vec_t'(1) << ((first + i) % MST_NB), ar_order[i]);
        end
    endtask

    //////////////////////////////
    // Tests
    //////////////////////////////

    task automatic single_burst();
        fill_model(8'h10, 4);
        do_write(0, make_id(0, 4'h3), 8'h10, 4, "t1_b");
        do_read(0, make_id(0, 4'h7), 8'h10, 4, 1'b0, "t1_r");
    endtask

    // Reset first so both arbiters start at master 0
    task automatic ar_rotation();
        apply_reset();
        ar_order.delete();
        fork
            do_read(0, make_id(0, 4'h1), 8'h10, 1, 1'b0, "t2_m0");
            do_read(1, make_id(1, 4'h1), 8'h11, 1, 1'b0, "t2_m1");
            do_read(2, make_id(2, 4'h1), 8'h12, 1, 1'b0, "t2_m2");
            do_read(3, make_id(3, 4'h1), 8'h13, 1, 1'b0, "t2_m3");
        join
        check_ar_order("t2_round1", 0);
        do_read(2, make_id(2, 4'h5), 8'h12, 1, 1'b0, "t2_m2_alone");
        ar_order.delete();
        fork
            do_read(0, make_id(0, 4'h6), 8'h10, 1, 1'b0, "t2_m0");
            do_read(1, make_id(1, 4'h6), 8'h11, 1, 1'b0, "t2_m1");
            do_read(2, make_id(2, 4'h6), 8'h12, 1, 1'b0, "t2_m2");
            do_read(3, make_id(3, 4'h6), 8'h13, 1, 1'b0, "t2_m3");
        join
        check_ar_order("t2_round2", 3);
    endtask

    task automatic parallel_writes();
        for (int m = 0; m < MST_NB; m++) begin
            fill_model(addr_t'(8'h40 + 16 * m), m + 2);
        end
        b_seen = '{default: 0};
        fork
            do_write(0, make_id(0, 4'hC), 8'h40, 2, "t3_b0");
            do_write(1, make_id(1, 4'hC), 8'h50, 3, "t3_b1");
            do_write(2, make_id(2, 4'hC), 8'h60, 4, "t3_b2");
            do_write(3, make_id(3, 4'hC), 8'h70, 5, "t3_b3");
        join
        // All B channels open so that any stray extra response is counted
        bready = '1;
        repeat (8) @(negedge aclk);
        bready = '0;
        for (int m = 0; m < MST_NB; m++) begin
            if (b_seen[m] != 1) begin
                $display("t3: master %0d got %0d write responses instead of one", m, b_seen[m]);
                n_proto_err++;
            end
            do_read(m, make_id(m, 4'hD), addr_t'(8'h40 + 16 * m), m + 2, 1'b0, "t3_r");
        end
    endtask

    // Master 1 waits behind master 0, which holds back its data
    task automatic w_order_stall();
        id_t id0;
        id_t id1;
        id0 = make_id(0, 4'h9);
        id1 = make_id(1, 4'hA);
        fill_model(8'hA0, 3);
        fill_model(8'hB0, 2);
        w_done = '0;
        fork
            begin
                send_aw(0, id0, 8'hA0, len_t'(2));
                repeat (6) @(negedge aclk);
                send_w(0, 8'hA0, 3);
            end
            recv_b(0, id0, "t4_b0");
            begin
                repeat (2) @(negedge aclk);
                do_write(1, id1, 8'hB0, 2, "t4_b1");
            end
            while (!w_done[0]) begin
                @(negedge aclk);
                #1;
                check_grant("t4_wready_m1", '0, wready & (mst_vec_t'(1) << 1));
            end
        join
        do_read(0, id0, 8'hA0, 3, 1'b0, "t4_r0");
        do_read(1, id1, 8'hB0, 2, 1'b0, "t4_r1");
    endtask

    task automatic long_read_gaps();
        fill_model(8'hC0, 16);
        do_write(3, make_id(3, 4'h2), 8'hC0, 16, "t5_b3");
        do_read(2, make_id(2, 4'hE), 8'hC0, 16, 1'b1, "t5_r2");
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin
        rst_n   = 1'b0;
        awvalid = '0;
        awch    = '0;
        wvalid  = '0;
        wlast   = '0;
        wch     = '0;
        bready  = '0;
        arvalid = '0;
        arch    = '0;
        rready  = '0;
        w_done  = '0;
        b_seen  = '{default: 0};
        apply_reset();
        single_burst();
        ar_rotation();
        parallel_writes();
        w_order_stall();
        long_read_gaps();
        repeat (4) @(negedge aclk);
        $display("Errors: %0d value, %0d protocol, %0d assertion", n_value_err, n_proto_err,
                 UUT.u_checker.n_fail);
        if (n_value_err + n_proto_err + UUT.u_checker.n_fail == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
src/axicb_pkg.sv
src/axicb_slv_if.sv
src/axicb_round_robin.sv
src/axicb_scfifo.sv
src/axicb_mst_switch.sv
src/axicb_ram_slave.sv
src/axicb_top.sv
bench/axicb_checker.sv
bench/axicb_tb.sv
